// ==== flist.f ====
logic/pocket_pkg.sv
logic/program_loader.sv
logic/program_memory.sv
logic/bridge_regs.sv
logic/video_cleanup.sv
logic/audio_clock_gen.sv
logic/i2s_serializer.sv
logic/pocket_core_top.sv
verification/pocket_core_sva.sv
verification/pocket_core_tb.sv

// ==== logic/audio_clock_gen.sv ====
// 12.288 MHz MCLK from a fractional accumulator, period jitters by a cycle
// sclk_fall is a clk_74a enable, once every SCLK_DIV MCLK periods
// it lands on the cycle where MCLK goes low
`timescale 1ns/10ps

module audio_clock_gen (
  input  logic clk_74a,
  input  logic reset,
  output logic audio_mclk,
  output logic sclk_fall
);

  logic [pocket_pkg::MCLK_ACC_W-1:0] accum_q;
  logic                              mclk_q;
  logic [pocket_pkg::SCLK_DIV_W-1:0] div_q;
  logic                              wrap;
  logic                              mclk_fall;

  assign wrap      = (accum_q >= pocket_pkg::MCLK_ACC_W'(pocket_pkg::MCLK_WRAP));
  assign mclk_fall = wrap & mclk_q;

  //////////////////////////////
  // accumulator and mclk
  //////////////////////////////
  always_ff @(posedge clk_74a)
  begin
    if (reset)
    begin
      accum_q <= '0;
      mclk_q  <= 1'b0;
      div_q   <= '0;
    end
    else
    begin
      if (wrap)
      begin
        accum_q <= accum_q - pocket_pkg::MCLK_ACC_W'(pocket_pkg::MCLK_WRAP)
                           + pocket_pkg::MCLK_ACC_W'(pocket_pkg::MCLK_STEP);
        mclk_q  <= ~mclk_q;
      end
      else
      begin
        accum_q <= accum_q + pocket_pkg::MCLK_ACC_W'(pocket_pkg::MCLK_STEP);
      end
      // divider steps on mclk falling edges
      if (mclk_fall)
      begin
        div_q <= div_q + 1'b1;
      end
    end
  end

  // sclk is div msb, falls as the divider rolls over
  assign sclk_fall = mclk_fall &&
                     (div_q == pocket_pkg::SCLK_DIV_W'(pocket_pkg::SCLK_DIV - 1));

  assign audio_mclk = mclk_q;

endmodule

// ==== logic/bridge_regs.sv ====
// register block at REG_BASE for loader status and memory readback
// read data is combinational and only driven while bridge_rd is high
// REG_PGM_DATA settles 2 cycles after a write to REG_READ_ADDR
`timescale 1ns/10ps

module bridge_regs (
  input  logic                       clk_74a,
  input  logic                       reset,
  input  logic [31:0]                bridge_addr,
  input  logic [31:0]                bridge_wr_data,
  input  logic                       bridge_wr,
  input  logic                       bridge_rd,
  output logic [31:0]                bridge_rd_data,
  input  logic [31:0]                byte_count,
  input  logic                       loader_busy,
  output pocket_pkg::pgm_word_addr_t readback_addr,
  input  pocket_pkg::pgm_word_t      readback_data
);

  pocket_pkg::pgm_word_addr_t read_addr_q;
  logic [31:0]                rd_mux;
  logic                       read_addr_wr;

  assign read_addr_wr = bridge_wr &&
                        (bridge_addr == (pocket_pkg::REG_BASE + pocket_pkg::REG_READ_ADDR));

  // readback pointer, steers the memory read port
  always_ff @(posedge clk_74a)
  begin
    if (reset)
    begin
      read_addr_q <= '0;
    end
    else if (read_addr_wr)
    begin
      read_addr_q <= bridge_wr_data[pocket_pkg::PGM_WORD_ADDR_W-1:0];
    end
  end

  assign readback_addr = read_addr_q;

  //////////////////////////////
  // read mux
  //////////////////////////////
  always_comb
  begin
    case (bridge_addr)
      pocket_pkg::REG_BASE + pocket_pkg::REG_PGM_DATA:
        rd_mux = {16'h0000, readback_data};
      pocket_pkg::REG_BASE + pocket_pkg::REG_BYTE_COUNT:
        rd_mux = byte_count;
      pocket_pkg::REG_BASE + pocket_pkg::REG_LOADER_BUSY:
        rd_mux = {31'd0, loader_busy};
      pocket_pkg::REG_BASE + pocket_pkg::REG_READ_ADDR:
        rd_mux = {{(32 - pocket_pkg::PGM_WORD_ADDR_W){1'b0}}, read_addr_q};
      // unmapped reads as zero
      default:
        rd_mux = 32'd0;
    endcase
  end

  assign bridge_rd_data = bridge_rd ? rd_mux : 32'd0;

endmodule

// ==== logic/i2s_serializer.sv ====
// I2S, 32 slots per channel, 16 active bits MSB first after a one-slot delay
// sample_ready is a one-cycle strobe at each frame start (LRCK fall)
// no valid sample at that strobe gives a silent frame
`timescale 1ns/10ps

module i2s_serializer (
  input  logic                     clk_74a,
  input  logic                     reset,
  input  logic                     sclk_fall,
  input  logic                     sample_valid,
  input  pocket_pkg::audio_frame_t sample,
  output logic                     sample_ready,
  output logic                     audio_lrck,
  output logic                     audio_dac
);

  logic [pocket_pkg::SLOT_W-1:0]          slot_q;
  logic                                   lrck_q;
  logic                                   dac_q;
  logic [2*pocket_pkg::ACTIVE_BITS-1:0]   shift_q;
  logic                                   last_slot;
  logic                                   frame_start;

  assign last_slot   = (slot_q == pocket_pkg::SLOT_W'(pocket_pkg::BITS_PER_CHANNEL - 1));
  // frame begins where lrck falls, left channel next
  assign frame_start = sclk_fall & last_slot & lrck_q;

  assign sample_ready = frame_start;

  //////////////////////////////
  // slot counter and shifter
  //////////////////////////////
  always_ff @(posedge clk_74a)
  begin
    if (reset)
    begin
      slot_q  <= '0;
      lrck_q  <= 1'b0;
      dac_q   <= 1'b0;
      shift_q <= '0;
    end
    else if (sclk_fall)
    begin
      slot_q <= slot_q + 1'b1;
      if (last_slot)
      begin
        // switch channel, slot 0 is the delay slot
        lrck_q <= ~lrck_q;
        dac_q  <= 1'b0;
        if (lrck_q)
        begin
          // left in the top half, right shifts up behind it
          shift_q <= sample_valid ? sample : '0;
        end
      end
      else if (slot_q < pocket_pkg::SLOT_W'(pocket_pkg::ACTIVE_BITS))
      begin
        // slots 1..16 carry data
        dac_q   <= shift_q[2*pocket_pkg::ACTIVE_BITS-1];
        shift_q <= shift_q << 1;
      end
      else
      begin
        dac_q <= 1'b0;
      end
    end
  end

  assign audio_lrck = lrck_q;
  assign audio_dac  = dac_q;

endmodule

// ==== logic/pocket_core_top.sv ====
// core top with program loader, program memory, bridge registers,
// video cleanup and I2S audio, everything on clk_74a
// the cpu side of program memory is left as top-level fetch ports
`timescale 1ns/10ps

module pocket_core_top (
  input  logic                       clk_74a,
  input  logic                       reset,
  // bridge
  input  logic [31:0]                bridge_addr,
  input  logic                       bridge_rd,
  output logic [31:0]                bridge_rd_data,
  input  logic                       bridge_wr,
  input  logic [31:0]                bridge_wr_data,
  // cpu fetch
  input  pocket_pkg::pgm_word_addr_t pgm_fetch_addr,
  output pocket_pkg::pgm_word_t      pgm_fetch_data,
  // video
  input  pocket_pkg::video_in_t      video_in,
  output pocket_pkg::video_out_t     video_out,
  // audio
  input  logic                       sample_valid,
  input  pocket_pkg::audio_frame_t   sample,
  output logic                       sample_ready,
  output logic                       audio_mclk,
  output logic                       audio_lrck,
  output logic                       audio_dac
);

  pocket_pkg::pgm_byte_write_t byte_write;
  logic [31:0]                 byte_count;
  logic                        loader_busy;
  pocket_pkg::pgm_word_addr_t  readback_addr;
  pocket_pkg::pgm_word_t       readback_data;
  logic                        sclk_fall;

  //////////////////////////////
  // program path
  //////////////////////////////
  program_loader program_loader_inst (
    .clk_74a        (clk_74a),
    .reset          (reset),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_wr      (bridge_wr),
    .byte_write     (byte_write),
    .byte_count     (byte_count),
    .busy           (loader_busy)
  );

  program_memory program_memory_inst (
    .clk_74a       (clk_74a),
    .byte_write    (byte_write),
    .fetch_addr    (pgm_fetch_addr),
    .fetch_data    (pgm_fetch_data),
    .readback_addr (readback_addr),
    .readback_data (readback_data)
  );

  bridge_regs bridge_regs_inst (
    .clk_74a        (clk_74a),
    .reset          (reset),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_wr      (bridge_wr),
    .bridge_rd      (bridge_rd),
    .bridge_rd_data (bridge_rd_data),
    .byte_count     (byte_count),
    .loader_busy    (loader_busy),
    .readback_addr  (readback_addr),
    .readback_data  (readback_data)
  );

  // video to scaler
  video_cleanup video_cleanup_inst (
    .clk_74a   (clk_74a),
    .reset     (reset),
    .video_in  (video_in),
    .video_out (video_out)
  );

  //////////////////////////////
  // audio
  //////////////////////////////
  audio_clock_gen audio_clock_gen_inst (
    .clk_74a    (clk_74a),
    .reset      (reset),
    .audio_mclk (audio_mclk),
    .sclk_fall  (sclk_fall)
  );

  i2s_serializer i2s_serializer_inst (
    .clk_74a      (clk_74a),
    .reset        (reset),
    .sclk_fall    (sclk_fall),
    .sample_valid (sample_valid),
    .sample       (sample),
    .sample_ready (sample_ready),
    .audio_lrck   (audio_lrck),
    .audio_dac    (audio_dac)
  );

endmodule

// ==== logic/pocket_pkg.sv ====
// shared address map, widths and bus structs for the core
// program memory is 16K x 16 bits, loaded a byte at a time from the bridge
// all timing is in clk_74a cycles; audio rates assume a 74.25 MHz clock
package pocket_pkg;

  //////////////////////////////
  // program memory
  //////////////////////////////
  localparam int PGM_DEPTH       = 16384;
  localparam int PGM_WORD_ADDR_W = $clog2(PGM_DEPTH);
  localparam int PGM_BYTE_ADDR_W = PGM_WORD_ADDR_W + 1;

  typedef logic [PGM_WORD_ADDR_W-1:0] pgm_word_addr_t;
  typedef logic [PGM_BYTE_ADDR_W-1:0] pgm_byte_addr_t;
  typedef logic [15:0]                pgm_word_t;

  // one byte lane write, loader to memory
  typedef struct packed {
    logic           valid;
    pgm_byte_addr_t addr;
    logic [7:0]     data;
  } pgm_byte_write_t;

  //////////////////////////////
  // bridge map
  //////////////////////////////
  localparam logic [3:0]  BRIDGE_REGION_PGM = 4'h0;
  localparam logic [31:0] REG_BASE          = 32'hF000_0000;
  localparam logic [31:0] REG_PGM_DATA      = 32'h0000_0000;
  localparam logic [31:0] REG_BYTE_COUNT    = 32'h0000_0004;
  localparam logic [31:0] REG_LOADER_BUSY   = 32'h0000_000C;
  localparam logic [31:0] REG_READ_ADDR     = 32'h0000_0010;

  localparam int BYTES_PER_WRITE = 4;
  localparam int BYTE_IDX_W      = $clog2(BYTES_PER_WRITE);

  //////////////////////////////
  // video
  //////////////////////////////
  typedef struct packed {
    logic pixel;
    logic hsync;
    logic vsync;
    logic hblank;
    logic vblank;
  } video_in_t;

  typedef struct packed {
    logic [23:0] rgb;
    logic        de;
    logic        hs;
    logic        vs;
  } video_out_t;

  localparam logic [23:0] RGB_WHITE = 24'hFF_FFFF;
  localparam logic [23:0] RGB_BLACK = 24'h00_0000;

  //////////////////////////////
  // audio
  //////////////////////////////
  typedef struct packed {
    logic signed [15:0] left;
    logic signed [15:0] right;
  } audio_frame_t;

  // 74.25 MHz * 245760 / 742500 = 2 x 12.288 MHz toggles
  localparam int MCLK_STEP  = 245760;
  localparam int MCLK_WRAP  = 742500;
  localparam int MCLK_ACC_W = 20;

  localparam int SCLK_DIV   = 4;
  localparam int SCLK_DIV_W = $clog2(SCLK_DIV);

  localparam int BITS_PER_CHANNEL = 32;
  localparam int SLOT_W           = $clog2(BITS_PER_CHANNEL);
  localparam int ACTIVE_BITS      = 16;

endpackage

// ==== logic/program_loader.sv ====
// splits each 32-bit program write into four byte writes, MSB first
// no handshake: the host must leave BYTES_PER_WRITE cycles between writes
// a write arriving while busy restarts the sequence and drops the rest
`timescale 1ns/10ps

module program_loader (
  input  logic                        clk_74a,
  input  logic                        reset,
  input  logic [31:0]                 bridge_addr,
  input  logic [31:0]                 bridge_wr_data,
  input  logic                        bridge_wr,
  output pocket_pkg::pgm_byte_write_t byte_write,
  output logic [31:0]                 byte_count,
  output logic                        busy
);

  logic                              pgm_wr;
  logic [31:0]                       word_q;
  pocket_pkg::pgm_byte_addr_t        base_q;
  logic [pocket_pkg::BYTE_IDX_W-1:0] idx_q;
  logic                              busy_q;
  logic [31:0]                       count_q;

  // program region decode on the top nibble
  assign pgm_wr = bridge_wr && (bridge_addr[31:28] == pocket_pkg::BRIDGE_REGION_PGM);

  //////////////////////////////
  // sequencing
  //////////////////////////////
  always_ff @(posedge clk_74a)
  begin
    if (reset)
    begin
      busy_q  <= 1'b0;
      idx_q   <= '0;
      count_q <= '0;
    end
    else
    begin
      if (busy_q)
      begin
        // one byte leaves per busy cycle
        count_q <= count_q + 32'd1;
        idx_q   <= idx_q + 1'b1;
        if (idx_q == pocket_pkg::BYTE_IDX_W'(pocket_pkg::BYTES_PER_WRITE - 1))
        begin
          busy_q <= 1'b0;
        end
      end
      if (pgm_wr)
      begin
        busy_q <= 1'b1;
        idx_q  <= '0;
      end
    end
  end

  // word and base latch, word shifts up a byte per step
  always_ff @(posedge clk_74a)
  begin
    if (pgm_wr)
    begin
      word_q <= bridge_wr_data;
      base_q <= bridge_addr[pocket_pkg::PGM_BYTE_ADDR_W-1:0];
    end
    else if (busy_q)
    begin
      word_q <= word_q << 8;
    end
  end

  always_comb
  begin
    byte_write.valid = busy_q;
    byte_write.addr  = base_q + pocket_pkg::pgm_byte_addr_t'(idx_q);
    byte_write.data  = word_q[31:24];
  end

  assign byte_count = count_q;
  assign busy       = busy_q;

endmodule

// ==== logic/program_memory.sv ====
// 16-bit program store written one byte lane at a time
// even byte addresses fill the low half, odd ones the high half
// both read ports are registered, one cycle latency, no reset on contents
`timescale 1ns/10ps

module program_memory (
  input  logic                        clk_74a,
  input  pocket_pkg::pgm_byte_write_t byte_write,
  input  pocket_pkg::pgm_word_addr_t  fetch_addr,
  output pocket_pkg::pgm_word_t       fetch_data,
  input  pocket_pkg::pgm_word_addr_t  readback_addr,
  output pocket_pkg::pgm_word_t       readback_data
);

  // two byte lanes per word
  logic [1:0][7:0] mem [pocket_pkg::PGM_DEPTH];

  // byte lane write, addr bit 0 picks the lane
  always_ff @(posedge clk_74a)
  begin
    if (byte_write.valid)
    begin
      mem[byte_write.addr[pocket_pkg::PGM_BYTE_ADDR_W-1:1]][byte_write.addr[0]] <= byte_write.data;
    end
  end

  // cpu fetch port
  always_ff @(posedge clk_74a)
  begin
    fetch_data <= mem[fetch_addr];
  end

  // bridge readback port
  always_ff @(posedge clk_74a)
  begin
    readback_data <= mem[readback_addr];
  end

endmodule

// ==== logic/video_cleanup.sv ====
// scaler wants single-cycle sync pulses and black pixels outside de
// all outputs are registered, one cycle after the inputs
// sync inputs must already be in the clk_74a domain
`timescale 1ns/10ps

module video_cleanup (
  input  logic                   clk_74a,
  input  logic                   reset,
  input  pocket_pkg::video_in_t  video_in,
  output pocket_pkg::video_out_t video_out
);

  logic hs_prev;
  logic vs_prev;
  logic de;

  // active area when neither blank is set
  assign de = ~(video_in.hblank | video_in.vblank);

  always_ff @(posedge clk_74a)
  begin
    if (reset)
    begin
      hs_prev       <= 1'b0;
      vs_prev       <= 1'b0;
      video_out.rgb <= pocket_pkg::RGB_BLACK;
      video_out.de  <= 1'b0;
      video_out.hs  <= 1'b0;
      video_out.vs  <= 1'b0;
    end
    else
    begin
      // rising edge only, one cycle wide
      video_out.hs <= video_in.hsync & ~hs_prev;
      video_out.vs <= video_in.vsync & ~vs_prev;
      hs_prev      <= video_in.hsync;
      vs_prev      <= video_in.vsync;
      video_out.de <= de;
      // mono panel, white or black
      if (de && video_in.pixel)
      begin
        video_out.rgb <= pocket_pkg::RGB_WHITE;
      end
      else
      begin
        video_out.rgb <= pocket_pkg::RGB_BLACK;
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it, from the project root
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module pocket_core_tb \
  --Mdir "$BUILD_DIR" -o pocket_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/pocket_core_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  exit 1
fi
exit 0

// ==== verification/pocket_core_sva.sv ====
// assertions bound into pocket_core_top
// host must leave BYTES_PER_WRITE cycles between program writes
// video input is assumed low during reset for the sync pulse checks
`timescale 1ns/10ps

module pocket_core_sva (
  input logic                     clk_74a,
  input logic                     reset,
  input logic [31:0]              bridge_addr,
  input logic                     bridge_wr,
  input pocket_pkg::video_in_t    video_in,
  input pocket_pkg::video_out_t   video_out,
  input logic                     sample_valid,
  input pocket_pkg::audio_frame_t sample,
  input logic                     sample_ready,
  input logic                     audio_lrck
);

  logic pgm_wr;
  int   since_wr;

  assign pgm_wr = bridge_wr && (bridge_addr[31:28] == pocket_pkg::BRIDGE_REGION_PGM);

  // cycles since the last program write, saturating
  always_ff @(posedge clk_74a)
  begin
    if (reset)
    begin
      since_wr <= pocket_pkg::BYTES_PER_WRITE;
    end
    else if (pgm_wr)
    begin
      since_wr <= 1;
    end
    else if (since_wr < pocket_pkg::BYTES_PER_WRITE)
    begin
      since_wr <= since_wr + 1;
    end
  end

  //////////////////////////////
  // loader and video
  //////////////////////////////
  loader_spacing: assert property (@(posedge clk_74a) disable iff (reset)
    pgm_wr |-> since_wr >= pocket_pkg::BYTES_PER_WRITE)
    else $error("program writes closer than the loader sequence");

  hs_single: assert property (@(posedge clk_74a) disable iff (reset)
    video_out.hs |=> !video_out.hs)
    else $error("hs pulse longer than one cycle");

  hs_on_rise: assert property (@(posedge clk_74a) disable iff (reset)
    video_out.hs |-> $past(video_in.hsync) && !$past(video_in.hsync, 2))
    else $error("hs pulse without a rising hsync");

  vs_single: assert property (@(posedge clk_74a) disable iff (reset)
    video_out.vs |=> !video_out.vs)
    else $error("vs pulse longer than one cycle");

  //////////////////////////////
  // audio handshake
  //////////////////////////////
  ready_single: assert property (@(posedge clk_74a) disable iff (reset)
    sample_ready |=> !sample_ready)
    else $error("sample_ready high for more than one cycle");

  // strobe on the last right channel cycle, lrck falls right after it
  ready_at_frame: assert property (@(posedge clk_74a) disable iff (reset)
    sample_ready |-> audio_lrck ##1 !audio_lrck)
    else $error("sample_ready outside a frame boundary");

  source_holds: assert property (@(posedge clk_74a) disable iff (reset)
    sample_valid && !sample_ready |=> sample_valid && $stable(sample))
    else $error("sample source dropped or changed a frame before transfer");

endmodule

bind pocket_core_top pocket_core_sva pocket_core_sva_inst (
  .clk_74a      (clk_74a),
  .reset        (reset),
  .bridge_addr  (bridge_addr),
  .bridge_wr    (bridge_wr),
  .video_in     (video_in),
  .video_out    (video_out),
  .sample_valid (sample_valid),
  .sample       (sample),
  .sample_ready (sample_ready),
  .audio_lrck   (audio_lrck)
);

// ==== verification/pocket_core_tb.sv ====
// directed testbench for pocket_core_top, all timing counted in clk_74a cycles
// audio checks assume the 245760/742500 MCLK ratio and 32-slot I2S frames
// program memory has no reset, so only bytes that were written are compared
`timescale 1ns/10ps

module pocket_core_tb;

  // clk_74a cycles per I2S frame, 512 MCLK toggles rounded up
  localparam int FRAME_CYCLES = (2 * 2 * pocket_pkg::SCLK_DIV * pocket_pkg::BITS_PER_CHANNEL
                                 * pocket_pkg::MCLK_WRAP + pocket_pkg::MCLK_STEP - 1)
                                / pocket_pkg::MCLK_STEP;
  // audio test spans at most five frames, program and video a few hundred cycles
  localparam int TIMEOUT_CYCLES   = 6 * FRAME_CYCLES + 2000;
  localparam int MCLK_PER_CHANNEL = pocket_pkg::SCLK_DIV * pocket_pkg::BITS_PER_CHANNEL;
  localparam int PGM_WRITES       = 8;
  localparam int VIDEO_STEPS      = 48;
  localparam int AUDIO_FRAMES     = 3;

  logic                       clk_74a;
  logic                       reset;
  logic [31:0]                bridge_addr;
  logic                       bridge_rd;
  logic [31:0]                bridge_rd_data;
  logic                       bridge_wr;
  logic [31:0]                bridge_wr_data;
  pocket_pkg::pgm_word_addr_t pgm_fetch_addr;
  pocket_pkg::pgm_word_t      pgm_fetch_data;
  pocket_pkg::video_in_t      video_in;
  pocket_pkg::video_out_t     video_out;
  logic                       sample_valid;
  pocket_pkg::audio_frame_t   sample;
  logic                       sample_ready;
  logic                       audio_mclk;
  logic                       audio_lrck;
  logic                       audio_dac;

  logic [31:0]              lfsr;
  int                       error_count;
  int                       check_count;
  int                       cycle_count;
  // byte address to byte, every program byte written so far
  logic [7:0]               shadow [int];
  pocket_pkg::audio_frame_t exp_frames [$];

  // i2s monitor state
  logic                     lrck_prev;
  logic                     mclk_prev;
  int                       mclk_edges;
  int                       lrck_edges;
  int                       lrck_falls;
  int                       ready_count;
  int                       dac_bits_checked;
  int                       bit_idx;
  logic                     frame_active;
  logic                     exp_bit;
  pocket_pkg::audio_frame_t cur_frame;

  pocket_core_top pocket_core_top_inst (
    .clk_74a        (clk_74a),
    .reset          (reset),
    .bridge_addr    (bridge_addr),
    .bridge_rd      (bridge_rd),
    .bridge_rd_data (bridge_rd_data),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .pgm_fetch_addr (pgm_fetch_addr),
    .pgm_fetch_data (pgm_fetch_data),
    .video_in       (video_in),
    .video_out      (video_out),
    .sample_valid   (sample_valid),
    .sample         (sample),
    .sample_ready   (sample_ready),
    .audio_mclk     (audio_mclk),
    .audio_lrck     (audio_lrck),
    .audio_dac      (audio_dac)
  );

  initial
  begin
    clk_74a = 1'b0;
    forever #10 clk_74a = ~clk_74a;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic expect_equal(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
    check_count++;
    if (got !== expected)
    begin
      error_count++;
      $display("[FAIL] %0t: %s, got %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic report_stall(input string what);
    error_count++;
    $display("%0t: %s", $time, what);
  endtask

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0])
    begin
      next = next ^ 32'h8020_0003;
    end
    return next;
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < n; i++)
    begin
      value = {value[30:0], lfsr[0]};
      lfsr  = lfsr_step(lfsr);
    end
  endtask

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk_74a);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(negedge clk_74a);
    bridge_wr      = 1'b0;
  endtask

  // read data is combinational, sampled one cycle after the address
  task automatic bridge_read(input logic [31:0] addr, output logic [31:0] data);
    @(negedge clk_74a);
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    @(negedge clk_74a);
    data        = bridge_rd_data;
    bridge_rd   = 1'b0;
  endtask

  task automatic wait_loader_idle();
    logic [31:0] busy;
    int          tries;
    busy  = 32'd1;
    tries = 0;
    while (busy != 32'd0 && tries < 16)
    begin
      bridge_read(pocket_pkg::REG_BASE + pocket_pkg::REG_LOADER_BUSY, busy);
      // first read lands inside the four byte write cycles
      if (tries == 0)
      begin
        expect_equal("loader busy right after a write", busy, 32'd1);
      end
      tries++;
    end
    if (busy != 32'd0)
    begin
      report_stall("program loader still busy 16 reads after a write");
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic load_program_words();
    int          byte_addr;
    int          k;
    int          i;
    logic [31:0] data;
    for (k = 0; k < PGM_WRITES; k++)
    begin
      // first half word aligned, second half starting on an odd byte
      if (k < PGM_WRITES / 2)
      begin
        byte_addr = 'h100 + 4 * k;
      end
      else
      begin
        byte_addr = 'h201 + 4 * (k - PGM_WRITES / 2);
      end
      draw_bits(32, data);
      bridge_write({pocket_pkg::BRIDGE_REGION_PGM, 28'(byte_addr)}, data);
      // msb lands at the base address
      for (i = 0; i < pocket_pkg::BYTES_PER_WRITE; i++)
      begin
        shadow[byte_addr + i] = data[31 - 8 * i -: 8];
      end
      wait_loader_idle();
    end
    // even byte in the low half, only fully written words
    foreach (shadow[b])
    begin
      if (b % 2 == 0 && shadow.exists(b + 1))
      begin
        @(negedge clk_74a);
        pgm_fetch_addr = pocket_pkg::pgm_word_addr_t'(b / 2);
        @(negedge clk_74a);
        expect_equal($sformatf("fetch of word %0h", b / 2), 32'(pgm_fetch_data),
                     {16'h0000, shadow[b + 1], shadow[b]});
      end
    end
  endtask

  task automatic confirm_byte_count();
    logic [31:0] value;
    bridge_read(pocket_pkg::REG_BASE + pocket_pkg::REG_BYTE_COUNT, value);
    expect_equal("byte count", value, 32'(pocket_pkg::BYTES_PER_WRITE * PGM_WRITES));
    bridge_read(pocket_pkg::REG_BASE + pocket_pkg::REG_LOADER_BUSY, value);
    expect_equal("loader busy when idle", value, 32'd0);
  endtask

  task automatic probe_register_map();
    logic [31:0] value;
    foreach (shadow[b])
    begin
      if (b % 2 == 0 && shadow.exists(b + 1))
      begin
        bridge_write(pocket_pkg::REG_BASE + pocket_pkg::REG_READ_ADDR, 32'(b / 2));
        // pointer register, then registered memory read
        repeat (2) @(negedge clk_74a);
        bridge_read(pocket_pkg::REG_BASE + pocket_pkg::REG_PGM_DATA, value);
        expect_equal($sformatf("readback of word %0h", b / 2), value,
                     {16'h0000, shadow[b + 1], shadow[b]});
        bridge_read(pocket_pkg::REG_BASE + pocket_pkg::REG_READ_ADDR, value);
        expect_equal("read address echo", value, 32'(b / 2));
      end
    end
    bridge_read(pocket_pkg::REG_BASE + 32'h0000_0008, value);
    expect_equal("unmapped offset 0x08", value, 32'd0);
    bridge_read(pocket_pkg::REG_BASE + 32'h0000_0014, value);
    expect_equal("unmapped offset 0x14", value, 32'd0);
  endtask

  task automatic sweep_video_patterns();
    pocket_pkg::video_in_t  last;
    pocket_pkg::video_in_t  cur;
    pocket_pkg::video_out_t expected;
    logic [31:0]            bits;
    int                     i;
    last = video_in;
    cur  = video_in;
    for (i = 0; i <= VIDEO_STEPS; i++)
    begin
      @(negedge clk_74a);
      // outputs now show cur, with last as the previous sync level
      expected.hs  = cur.hsync & ~last.hsync;
      expected.vs  = cur.vsync & ~last.vsync;
      expected.de  = ~(cur.hblank | cur.vblank);
      expected.rgb = (expected.de && cur.pixel) ? pocket_pkg::RGB_WHITE : pocket_pkg::RGB_BLACK;
      expect_equal($sformatf("video out, step %0d", i), 32'(video_out), 32'(expected));
      if (i < VIDEO_STEPS)
      begin
        draw_bits(3, bits);
        last       = cur;
        // syncs held for several cycles so pulses must stay one wide
        cur.hsync  = ((i % 7) < 3);
        cur.vsync  = ((i % 11) < 4);
        cur.hblank = bits[0];
        cur.vblank = bits[1];
        cur.pixel  = bits[2];
        video_in   = cur;
      end
    end
  endtask

  task automatic stream_audio_frames();
    logic [31:0] bits;
    int          n;
    int          waited;
    // two random frames, a silent one, then the closing strobe
    for (n = 0; n <= AUDIO_FRAMES; n++)
    begin
      if (n < AUDIO_FRAMES - 1)
      begin
        draw_bits(32, bits);
        sample       = pocket_pkg::audio_frame_t'(bits);
        sample_valid = 1'b1;
      end
      else
      begin
        // stale data left on sample, valid low must still give zeros
        sample_valid = 1'b0;
      end
      waited = 0;
      while (!sample_ready && waited <= FRAME_CYCLES + 8)
      begin
        @(negedge clk_74a);
        waited++;
      end
      if (!sample_ready)
      begin
        report_stall("sample_ready did not pulse within one audio frame");
      end
      else
      begin
        if (n < AUDIO_FRAMES)
        begin
          exp_frames.push_back(sample_valid ? sample : '0);
        end
        @(negedge clk_74a);
        expect_equal("sample_ready after transfer", 32'(sample_ready), 32'd0);
      end
    end
    sample_valid = 1'b0;
    expect_equal("frames left unsent", 32'(exp_frames.size()), 32'd0);
    expect_equal("dac bits checked", 32'(dac_bits_checked),
                 32'(AUDIO_FRAMES * 2 * pocket_pkg::ACTIVE_BITS));
  endtask

  //////////////////////////////
  // i2s monitor
  //////////////////////////////
  // slot k of a channel is mid-way at mclk rise 4k+2 after the lrck edge
  always @(negedge clk_74a)
  begin
    if (reset)
    begin
      lrck_prev        = 1'b0;
      mclk_prev        = 1'b0;
      mclk_edges       = 0;
      lrck_edges       = 0;
      lrck_falls       = 0;
      ready_count      = 0;
      dac_bits_checked = 0;
      frame_active     = 1'b0;
    end
    else
    begin
      if (audio_lrck != lrck_prev)
      begin
        if (lrck_edges > 0)
        begin
          expect_equal("mclk rises per lrck half", 32'(mclk_edges), 32'(MCLK_PER_CHANNEL));
        end
        lrck_edges++;
        mclk_edges = 0;
        if (!audio_lrck)
        begin
          // frame start, one ready strobe per frame
          if (lrck_falls > 0)
          begin
            expect_equal("ready strobes per frame", 32'(ready_count), 32'd1);
          end
          lrck_falls++;
          ready_count  = 0;
          frame_active = (exp_frames.size() > 0);
          if (frame_active)
          begin
            cur_frame = exp_frames.pop_front();
          end
        end
      end
      else if (audio_mclk && !mclk_prev)
      begin
        mclk_edges++;
        if (frame_active && mclk_edges >= 6 && (mclk_edges - 6) % 4 == 0 &&
            (mclk_edges - 6) / 4 < pocket_pkg::ACTIVE_BITS)
        begin
          bit_idx = pocket_pkg::ACTIVE_BITS - 1 - (mclk_edges - 6) / 4;
          exp_bit = audio_lrck ? cur_frame.right[bit_idx] : cur_frame.left[bit_idx];
          expect_equal($sformatf("dac bit %0d, lrck %0b", bit_idx, audio_lrck),
                       32'(audio_dac), 32'(exp_bit));
          dac_bits_checked++;
        end
      end
      if (sample_ready)
      begin
        ready_count++;
      end
      lrck_prev = audio_lrck;
      mclk_prev = audio_mclk;
    end
  end

  // run limit
  always @(posedge clk_74a)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial
  begin
    reset          = 1'b1;
    bridge_addr    = 32'd0;
    bridge_rd      = 1'b0;
    bridge_wr      = 1'b0;
    bridge_wr_data = 32'd0;
    pgm_fetch_addr = '0;
    video_in       = '0;
    sample_valid   = 1'b0;
    sample         = '0;
    lfsr           = 32'ha413;
    error_count    = 0;
    check_count    = 0;
    cycle_count    = 0;
    repeat (16) @(negedge clk_74a);
    reset = 1'b0;

    load_program_words();
    confirm_byte_count();
    probe_register_map();
    sweep_video_patterns();
    stream_audio_frames();

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
